// ==== verilog/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'h0000_1000

// address split is tag | index | offset
`define TAG_BITS 20
`define INDEX_BITS 7
`define OFFSET_BITS 5

// two ways of this many sets each
`define ICACHE_SETS (1 << `INDEX_BITS)

// 32-byte line, must equal 2**(OFFSET_BITS-2)
`define LINE_WORDS 8

// power of two so the pointers wrap naturally
`define QUEUE_DEPTH 4

`endif

// ==== verilog/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    typedef logic [`TAG_BITS-1:0]   tag_t;
    typedef logic [`INDEX_BITS-1:0] index_t;

    // word 0 at the lowest address
    typedef logic [`LINE_WORDS-1:0][31:0] line_t;

    // generator to cache
    typedef struct packed {
        addr_t pc;
    } fetch_req_t;

    // cache to queue, queue to decode
    typedef struct packed {
        addr_t pc;
        word_t inst;
    } fetch_pkt_t;

    typedef enum logic [1:0] {
        LOOKUP,
        REFILL,
        RESPOND
    } icache_state_e;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,   // AR beat outstanding
        DATA,   // waiting on R beat
        DONE
    } refill_state_e;

endpackage

// ==== verilog/fetch_pc_gen.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_pc_gen (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  redirect_valid_i,
    input  fetch_pkg::addr_t      redirect_pc_i,
    output logic                  req_valid_o,
    output fetch_pkg::fetch_req_t req_o,
    input  logic                  req_ready_i
);
    import fetch_pkg::*;

    addr_t pc_q;
    logic  valid_q;
    logic  req_fire;

    // no request goes out on the flush cycle, the old pc is dead
    assign req_valid_o = valid_q && !redirect_valid_i;
    assign req_fire    = req_valid_o && req_ready_i;

    assign req_o.pc = pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q    <= `FETCH_RESET_PC;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;  // fetch starts once out of reset
            if (redirect_valid_i) begin
                pc_q <= redirect_pc_i;
            end else if (req_fire) begin
                pc_q <= pc_q + 32'd4;  // next sequential word
            end
        end
    end

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module icache (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  redirect_valid_i,
    input  logic                  req_valid_i,
    input  fetch_pkg::fetch_req_t req_i,
    output logic                  req_ready_o,
    output logic                  pkt_valid_o,
    output fetch_pkg::fetch_pkt_t pkt_o,
    input  logic                  pkt_ready_i,
    output logic                  refill_start_o,
    output fetch_pkg::addr_t      refill_addr_o,
    input  logic                  refill_done_i,
    input  fetch_pkg::line_t      refill_line_i
);
    import fetch_pkg::*;

    // inferred arrays, two ways
    tag_t  tag_mem  [2][`ICACHE_SETS];
    line_t data_mem [2][`ICACHE_SETS];

    logic [`ICACHE_SETS-1:0][1:0] valid_q;
    logic [`ICACHE_SETS-1:0]      lru_q;   // way to replace next

    icache_state_e state_q;

    // lookup stage, filled by the synchronous array read
    logic       lk_valid_q;
    addr_t      lk_pc_q;
    tag_t       rd_tag_q  [2];
    line_t      rd_line_q [2];
    logic [1:0] rd_vld_q;

    logic       redir_pend_q;
    word_t      fill_inst_q;
    logic       pkt_valid_q;
    fetch_pkt_t pkt_q;

    index_t                  req_idx;
    index_t                  lk_idx;
    tag_t                    lk_tag;
    logic [`OFFSET_BITS-3:0] lk_word;
    logic [1:0]              way_hit;
    logic                    hit;
    logic                    hit_way;
    logic                    victim;
    logic                    out_free;
    logic                    req_fire;
    logic                    load_hit;
    logic                    load_fill;
    logic                    fill_write;

    assign req_idx = req_i.pc[`OFFSET_BITS +: `INDEX_BITS];
    assign lk_idx  = lk_pc_q[`OFFSET_BITS +: `INDEX_BITS];
    assign lk_tag  = lk_pc_q[31 -: `TAG_BITS];
    assign lk_word = lk_pc_q[`OFFSET_BITS-1:2];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = rd_vld_q[w] && (rd_tag_q[w] == lk_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    assign victim  = lru_q[lk_idx];

    // output register empty or leaving this cycle
    assign out_free = !pkt_valid_q || pkt_ready_i;

    // a missing lookup blocks new requests
    assign req_ready_o = (state_q == LOOKUP) && out_free && !(lk_valid_q && !hit);
    assign req_fire    = req_valid_i && req_ready_o;

    assign load_hit   = (state_q == LOOKUP) && lk_valid_q && hit && out_free;
    assign load_fill  = (state_q == RESPOND) && !redir_pend_q && out_free;
    assign fill_write = (state_q == REFILL) && refill_done_i;

    assign refill_start_o = (state_q == LOOKUP) && lk_valid_q && !hit && !redirect_valid_i;
    assign refill_addr_o  = {lk_pc_q[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};

    assign pkt_valid_o = pkt_valid_q;
    assign pkt_o       = pkt_q;

    always_ff @(posedge clk) begin
        if (req_fire) begin
            lk_pc_q  <= req_i.pc;
            rd_vld_q <= valid_q[req_idx];
            for (int w = 0; w < 2; w++) begin
                rd_tag_q[w]  <= tag_mem[w][req_idx];
                rd_line_q[w] <= data_mem[w][req_idx];
            end
        end
        if (fill_write) begin
            tag_mem[victim][lk_idx]  <= lk_tag;
            data_mem[victim][lk_idx] <= refill_line_i;
            fill_inst_q              <= refill_line_i[lk_word];  // word that missed
        end
        if (load_hit) begin
            pkt_q.pc   <= lk_pc_q;
            pkt_q.inst <= rd_line_q[hit_way][lk_word];
        end else if (load_fill) begin
            pkt_q.pc   <= lk_pc_q;
            pkt_q.inst <= fill_inst_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q      <= LOOKUP;
            lk_valid_q   <= 1'b0;
            redir_pend_q <= 1'b0;
            pkt_valid_q  <= 1'b0;
            valid_q      <= '0;
            lru_q        <= '0;
        end else begin
            case (state_q)
                LOOKUP:  if (refill_start_o) state_q <= REFILL;
                REFILL:  if (refill_done_i) state_q <= RESPOND;
                RESPOND: if (redir_pend_q || redirect_valid_i || out_free) state_q <= LOOKUP;
                default: state_q <= LOOKUP;
            endcase

            if (redirect_valid_i) begin
                lk_valid_q <= 1'b0;
            end else if (req_fire) begin
                lk_valid_q <= 1'b1;
            end else if (load_hit || (state_q == RESPOND && out_free)) begin
                lk_valid_q <= 1'b0;
            end

            // flush during refill, line is kept but its answer dropped
            if (state_q == RESPOND) begin
                redir_pend_q <= 1'b0;
            end else if (state_q == REFILL && redirect_valid_i) begin
                redir_pend_q <= 1'b1;
            end

            if (load_hit) begin
                lru_q[lk_idx] <= ~hit_way;
            end
            if (fill_write) begin
                valid_q[lk_idx][victim] <= 1'b1;
                lru_q[lk_idx]           <= ~victim;
            end

            if (redirect_valid_i) begin
                pkt_valid_q <= 1'b0;
            end else if (load_hit || load_fill) begin
                pkt_valid_q <= 1'b1;
            end else if (pkt_ready_i) begin
                pkt_valid_q <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/refill_axi_master.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module refill_axi_master (
    input  logic             clk,
    input  logic             reset,
    input  logic             refill_start_i,
    input  fetch_pkg::addr_t refill_addr_i,
    output logic             refill_done_o,
    output fetch_pkg::line_t refill_line_o,
    output logic             arvalid_o,
    output fetch_pkg::addr_t araddr_o,
    input  logic             arready_i,
    input  logic             rvalid_i,
    input  fetch_pkg::word_t rdata_i,
    output logic             rready_o
);
    import fetch_pkg::*;

    refill_state_e           state_q;
    logic [`OFFSET_BITS-3:0] cnt_q;    // word within the line
    logic [31:`OFFSET_BITS]  base_q;   // line address
    line_t                   line_q;

    assign arvalid_o     = (state_q == ADDR);
    assign rready_o      = (state_q == DATA);
    assign refill_done_o = (state_q == DONE);
    assign refill_line_o = line_q;

    // stable while arvalid is up, counter only moves in DATA
    assign araddr_o = {base_q, cnt_q, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (refill_start_i) begin
                        cnt_q   <= '0;
                        state_q <= ADDR;
                    end
                end
                ADDR: if (arready_i) state_q <= DATA;
                DATA: begin
                    if (rvalid_i) begin
                        if (&cnt_q) begin
                            state_q <= DONE;  // last word in
                        end else begin
                            cnt_q   <= cnt_q + 1'b1;
                            state_q <= ADDR;
                        end
                    end
                end
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && refill_start_i) begin
            base_q <= refill_addr_i[31:`OFFSET_BITS];
        end
        if (state_q == DATA && rvalid_i) begin
            line_q[cnt_q] <= rdata_i;
        end
    end

endmodule

// ==== verilog/inst_queue.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module inst_queue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  redirect_valid_i,
    input  logic                  pkt_valid_i,
    input  fetch_pkg::fetch_pkt_t pkt_i,
    output logic                  pkt_ready_o,
    output logic                  inst_valid_o,
    output fetch_pkg::fetch_pkt_t inst_o,
    input  logic                  inst_ready_i
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(`QUEUE_DEPTH);

    fetch_pkt_t       mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign pkt_ready_o  = (count_q != FULL_COUNT);
    assign inst_valid_o = (count_q != '0);
    assign inst_o       = mem[rd_ptr_q];

    assign push = pkt_valid_i && pkt_ready_o;
    assign pop  = inst_valid_o && inst_ready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= pkt_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || redirect_valid_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // none or both
            endcase
        end
    end

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  redirect_valid_i,
    input  fetch_pkg::addr_t      redirect_pc_i,
    output logic                  inst_valid_o,
    output fetch_pkg::fetch_pkt_t inst_o,
    input  logic                  inst_ready_i,
    output logic                  arvalid_o,
    output fetch_pkg::addr_t      araddr_o,
    input  logic                  arready_i,
    input  logic                  rvalid_i,
    input  fetch_pkg::word_t      rdata_i,
    output logic                  rready_o
);
    import fetch_pkg::*;

    logic       req_valid;
    logic       req_ready;
    fetch_req_t req;
    logic       pkt_valid;
    logic       pkt_ready;
    fetch_pkt_t pkt;
    logic       refill_start;
    addr_t      refill_addr;
    logic       refill_done;
    line_t      refill_line;

    fetch_pc_gen u_pc_gen (
        .clk              (clk),
        .reset            (reset),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .req_valid_o      (req_valid),
        .req_o            (req),
        .req_ready_i      (req_ready)
    );

    icache u_icache (
        .clk              (clk),
        .reset            (reset),
        .redirect_valid_i (redirect_valid_i),
        .req_valid_i      (req_valid),
        .req_i            (req),
        .req_ready_o      (req_ready),
        .pkt_valid_o      (pkt_valid),
        .pkt_o            (pkt),
        .pkt_ready_i      (pkt_ready),
        .refill_start_o   (refill_start),
        .refill_addr_o    (refill_addr),
        .refill_done_i    (refill_done),
        .refill_line_i    (refill_line)
    );

    refill_axi_master u_refill (
        .clk            (clk),
        .reset          (reset),
        .refill_start_i (refill_start),
        .refill_addr_i  (refill_addr),
        .refill_done_o  (refill_done),
        .refill_line_o  (refill_line),
        .arvalid_o      (arvalid_o),
        .araddr_o       (araddr_o),
        .arready_i      (arready_i),
        .rvalid_i       (rvalid_i),
        .rdata_i        (rdata_i),
        .rready_o       (rready_o)
    );

    inst_queue u_queue (
        .clk              (clk),
        .reset            (reset),
        .redirect_valid_i (redirect_valid_i),
        .pkt_valid_i      (pkt_valid),
        .pkt_i            (pkt),
        .pkt_ready_o      (pkt_ready),
        .inst_valid_o     (inst_valid_o),
        .inst_o           (inst_o),
        .inst_ready_i     (inst_ready_i)
    );

endmodule

// ==== tb/axi_mem_model.sv ====
`timescale 1ns/10ps

module axi_mem_model (
    input  logic             clk,
    input  logic             reset,
    input  logic             arvalid_i,
    input  fetch_pkg::addr_t araddr_i,
    output logic             arready_o,
    output logic             rvalid_o,
    output fetch_pkg::word_t rdata_o,
    input  logic             rready_i
);
    import fetch_pkg::*;

    integer    seed = 32'hc6ca_7f6c;
    logic [1:0] ar_wait_q;   // cycles before arready
    logic [1:0] r_wait_q;    // cycles before rvalid
    logic       pending_q;   // address taken, data not yet up
    addr_t      addr_q;

    always @(posedge clk) begin
        if (reset) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rdata_o   <= '0;
            pending_q <= 1'b0;
            addr_q    <= '0;
            ar_wait_q <= 2'($random(seed));
            r_wait_q  <= '0;
        end else begin
            if (arvalid_i && arready_o) begin
                arready_o <= 1'b0;
                addr_q    <= araddr_i;
                pending_q <= 1'b1;
                r_wait_q  <= 2'($random(seed));
            end else if (arvalid_i && !pending_q && !rvalid_o) begin
                if (ar_wait_q == 2'd0) begin
                    arready_o <= 1'b1;
                end else begin
                    ar_wait_q <= ar_wait_q - 2'd1;
                end
            end

            if (pending_q && !rvalid_o) begin
                if (r_wait_q == 2'd0) begin
                    rvalid_o  <= 1'b1;
                    rdata_o   <= addr_q ^ 32'h5a5a_0000;  // fixed data rule
                    pending_q <= 1'b0;
                end else begin
                    r_wait_q <= r_wait_q - 2'd1;
                end
            end

            if (rvalid_o && rready_i) begin
                rvalid_o  <= 1'b0;
                ar_wait_q <= 2'($random(seed));
            end
        end
    end

endmodule

// ==== tb/fetch_tb.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       redirect_valid_i = 1'b0;
    addr_t      redirect_pc_i = '0;
    logic       inst_ready_i = 1'b1;
    logic       inst_valid_o;
    fetch_pkt_t inst_o;
    logic       arvalid_o;
    addr_t      araddr_o;
    logic       arready_i;
    logic       rvalid_i;
    word_t      rdata_i;
    logic       rready_o;

    integer seed = 32'hc6ca_7f6c;
    int     error_count = 0;
    int     accepted = 0;
    addr_t  exp_pc;
    logic   toggle_ready = 1'b0;
    logic   stall_ready = 1'b0;
    logic   accept;
    logic   ar_fire;
    logic [2:0] ar_idx;
    addr_t  last_ar;
    addr_t  exp_araddr;
    logic   r_pending;
    addr_t  ar_log[$];

    fetch_top u_fetch_top (
        .clk              (clk),
        .reset            (reset),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .inst_valid_o     (inst_valid_o),
        .inst_o           (inst_o),
        .inst_ready_i     (inst_ready_i),
        .arvalid_o        (arvalid_o),
        .araddr_o         (araddr_o),
        .arready_i        (arready_i),
        .rvalid_i         (rvalid_i),
        .rdata_i          (rdata_i),
        .rready_o         (rready_o)
    );

    axi_mem_model u_mem (
        .clk       (clk),
        .reset     (reset),
        .arvalid_i (arvalid_o),
        .araddr_i  (araddr_o),
        .arready_o (arready_i),
        .rvalid_o  (rvalid_i),
        .rdata_o   (rdata_i),
        .rready_i  (rready_o)
    );

    always #10 clk = ~clk;

    assign accept     = inst_valid_o && inst_ready_i && !redirect_valid_i;
    assign ar_fire    = arvalid_o && arready_i;
    assign exp_araddr = (ar_idx == 3'd0) ? {araddr_o[31:5], 5'b0} : last_ar + 32'd4;

    // decode side ready
    always @(posedge clk) begin
        if (reset) begin
            inst_ready_i <= 1'b1;
        end else if (stall_ready) begin
            inst_ready_i <= 1'b0;
        end else if (toggle_ready) begin
            inst_ready_i <= ($random(seed) & 1) == 1;
        end else begin
            inst_ready_i <= 1'b1;
        end
    end

    // scoreboard, expected next pc
    always @(posedge clk) begin
        if (reset) begin
            exp_pc   <= `FETCH_RESET_PC;
            accepted <= 0;
        end else if (redirect_valid_i) begin
            exp_pc <= redirect_pc_i;
        end else if (accept) begin
            exp_pc   <= exp_pc + 32'd4;
            accepted <= accepted + 1;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            ar_idx  <= '0;
            last_ar <= '0;
        end else if (ar_fire) begin
            ar_idx  <= ar_idx + 3'd1;  // wraps per line
            last_ar <= araddr_o;
            ar_log.push_back(araddr_o);
        end
    end

    // one AR outstanding until its R beat
    always @(posedge clk) begin
        if (reset) begin
            r_pending <= 1'b0;
        end else if (ar_fire) begin
            r_pending <= 1'b1;
        end else if (rvalid_i && rready_o) begin
            r_pending <= 1'b0;
        end
    end

    a_pc: assert property (@(posedge clk) disable iff (reset) accept |-> inst_o.pc == exp_pc)
        else begin
            error_count++;
            $display("FAIL inst_o.pc got %h expected %h", inst_o.pc, exp_pc);
        end

    a_inst: assert property (@(posedge clk) disable iff (reset)
        accept |-> inst_o.inst == (exp_pc ^ 32'h5a5a_0000))
        else begin
            error_count++;
            $display("FAIL inst_o.inst got %h expected %h", inst_o.inst,
                     exp_pc ^ 32'h5a5a_0000);
        end

    a_reset_quiet: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!inst_valid_o && !arvalid_o && !rready_o))
        else begin
            error_count++;
            $display("inst_valid_o, arvalid_o or rready_o high while in reset");
        end

    a_ar_order: assert property (@(posedge clk) disable iff (reset)
        ar_fire |-> araddr_o == exp_araddr)
        else begin
            error_count++;
            $display("FAIL araddr_o got %h expected %h", araddr_o, exp_araddr);
        end

    a_ar_stable: assert property (@(posedge clk) disable iff (reset)
        (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o)))
        else begin
            error_count++;
            $display("arvalid_o dropped or araddr_o changed before arready");
        end

    a_rready: assert property (@(posedge clk) disable iff (reset) rready_o == r_pending)
        else begin
            error_count++;
            $display("FAIL rready_o got %h expected %h", rready_o, r_pending);
        end

    task automatic pulse_redirect(input addr_t pc);
        @(posedge clk);
        redirect_valid_i <= 1'b1;
        redirect_pc_i    <= pc;
        @(posedge clk);
        redirect_valid_i <= 1'b0;
    endtask

    task automatic wait_accepts(input int n);
        int target;
        int cycles;
        target = accepted + n;
        cycles = 0;
        while (accepted < target && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (accepted < target) begin
            error_count++;
            $display("timed out waiting for %0d accepted instructions", n);
        end
    endtask

    // until the refill of this line puts an address out
    task automatic wait_line_refill(input addr_t base);
        int cycles;
        cycles = 0;
        while (!(arvalid_o && araddr_o[31:5] == base[31:5]) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!(arvalid_o && araddr_o[31:5] == base[31:5])) begin
            error_count++;
            $display("timed out waiting for the refill of line %h", base);
        end
    endtask

    // fetch one whole line and count the AR beats that hit it
    task automatic fetch_line(input addr_t base, input int exp_ar);
        int start;
        int n;
        start = ar_log.size();
        n = 0;
        pulse_redirect(base);
        wait_accepts(`LINE_WORDS);
        for (int i = start; i < ar_log.size(); i++) begin
            if (ar_log[i][31:5] == base[31:5]) n++;
        end
        a_line_ar: assert (n == exp_ar)
            else begin
                error_count++;
                $display("FAIL ar count for line %h got %h expected %h", base, n, exp_ar);
            end
    endtask

    initial begin
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        wait_accepts(24);               // cold misses from reset
        fetch_line(`FETCH_RESET_PC, 0); // now a hit
        fetch_line(32'h0000_2000, `LINE_WORDS);

        // flush in the middle of a refill
        pulse_redirect(32'h0000_5000);
        wait_line_refill(32'h0000_5000);
        pulse_redirect(32'h0000_6004);
        wait_accepts(`LINE_WORDS);
        fetch_line(32'h0000_5000, 0);   // line was still written

        // same index, LRU picks B as victim for C
        fetch_line(32'h0002_0a00, `LINE_WORDS);
        fetch_line(32'h0003_0a00, `LINE_WORDS);
        fetch_line(32'h0002_0a00, 0);
        fetch_line(32'h0004_0a00, `LINE_WORDS);
        fetch_line(32'h0002_0a00, 0);
        fetch_line(32'h0003_0a00, `LINE_WORDS);

        // back-pressure
        pulse_redirect(32'h0000_8000);
        toggle_ready <= 1'b1;
        wait_accepts(40);
        stall_ready <= 1'b1;
        repeat (12) @(posedge clk);
        stall_ready <= 1'b0;
        wait_accepts(20);
        toggle_ready <= 1'b0;
        repeat (4) @(posedge clk);

        $display("accepted %0d instructions, %0d AR beats, %0d errors",
                 accepted, ar_log.size(), error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== fetch_top.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/icache.sv
verilog/refill_axi_master.sv
verilog/inst_queue.sv
verilog/fetch_top.sv
tb/axi_mem_model.sv
tb/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module fetch_tb \
    -f fetch_top.f --Mdir obj_dir -o fetch_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1
grep -q "All tests passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
